/* list.f */
rtl/lsu_pkg.sv
rtl/lsu_agen_stage.sv
rtl/lsu_lq_alloc.sv
rtl/lsu_dw_stage.sv
rtl/lsu_cfg_regs.sv
rtl/lsu_top.sv
verification/lsu_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = lsu_tb
FILELIST = list.f
OBJ_DIR  = obj_dir

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf $(OBJ_DIR)

.PHONY: sim clean

/* verification/lsu_tb.sv */
/*
 * Table-driven testbench for the LSU front end. Ops are issued one at a time,
 * so stages never overlap. The LQ model assumes the table never fills the queue.
 */

`timescale 1ns/1ps

module lsu_tb;

    import lsu_pkg::*;

    localparam int LQ_DEPTH        = 8;
    localparam int SQ_DEPTH        = 8;
    localparam int DC_OFFSET_WIDTH = 5;
    localparam int NUM_ROWS        = 12;

    typedef logic [LQ_DEPTH-1:0] sel_t;
    typedef logic [SQ_DEPTH-1:0] sq_sel_t;
    typedef logic [ADDR_WIDTH-1:DC_OFFSET_WIDTH] line_t;

    typedef struct {
        string      name;
        op_t        op;
        addr_t      base, offset;
        tag_t       tag;
        data_t      data;
        sel_t       own_sel, rel;
        line_t      fill_line;
        logic [1:0] flush;
        logic       replay, rnd, fill_en, fill_dw, exp_fill, exp_lookup;
    } row_t;

    // name, op, base, offset, tag, data, own select, release, fill line,
    // flush (1 agen, 2 DW), replay, random offset, fill, fill in DW, exp fill, exp lookup
    row_t rows [NUM_ROWS] = '{
        '{"ld_plain", OP_LOAD, 'h1000_0000, 'h24, 3, 'hCAFE_0001, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1},
        '{"st_plain", OP_STORE, 'h2000_0100, 'h8, 4, 'h5555_AAAA, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1},
        '{"ld_rand_a", OP_LOAD, 'h3000_0000, 0, 5, 'h1234, 0, 0, 0, 0, 0, 1, 0, 0, 0, 1},
        '{"ld_rand_b", OP_LOAD, 'h3000_4000, 0, 6, 'h5678, 0, 0, 0, 0, 0, 1, 0, 0, 0, 1},
        '{"ld_flush_ag", OP_LOAD, 'h5000_0000, 'h10, 7, 'hD004, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0},
        '{"ld_flush_dw", OP_LOAD, 'h5000_0000, 'h20, 8, 'hD005, 0, 0, 0, 2, 0, 0, 0, 0, 0, 0},
        '{"ld_fill_ag", OP_LOAD, 'h4000_0000, 'h40, 9, 'hF006, 0, 0, 'h200_0002, 0, 0, 0, 1, 0, 1, 0},
        '{"ld_fill_dw", OP_LOAD, 'h4000_0000, 'h7C, 10, 'hF007, 0, 0, 'h200_0003, 0, 0, 0, 1, 1, 1, 0},
        '{"ld_fill_oth", OP_LOAD, 'h4000_0000, 'h80, 11, 'hF008, 0, 0, 'h200_0000, 0, 0, 0, 1, 0, 0, 1},
        '{"ld_replay", OP_LOAD, 'h1000_0000, 'h24, 3, 'hCAFE_0009, 'h01, 0, 0, 0, 1, 0, 0, 0, 0, 1},
        '{"ld_release", OP_LOAD, 'h6000_0000, 'h4, 12, 'hB00A, 0, 'h02, 0, 0, 0, 0, 0, 0, 0, 1},
        '{"st_fill_oth", OP_STORE, 'h7000_0000, 0, 13, 'hB00B, 0, 0, 'h380_0080, 0, 0, 0, 1, 1, 0, 1}
    };

    logic        clk = 1'b0;
    logic        i_arst_n = 1'b0, i_flush = 1'b0, i_fill_en = 1'b0, i_valid = 1'b0;
    logic        i_retire = 1'b0, i_replay = 1'b0;
    logic        i_psel = 1'b0, i_penable = 1'b0, i_pwrite = 1'b0;
    line_t       i_fill_addr = '0;
    op_t         i_op = OP_LOAD;
    op_is_t      i_op_is = '0;
    tag_t        i_tag = '0;
    addr_t       i_base = '0, i_offset = '0;
    data_t       i_data = '0;
    sel_t        i_lq_select = '0, i_lq_free = '0;
    logic [SQ_DEPTH-1:0] i_sq_select = '0;
    apb_addr_t   i_paddr = '0;
    logic [31:0] i_pwdata = '0;

    logic        o_valid, o_mhq_lookup_valid, o_fill_replay, o_retire, o_pready, o_pslverr;
    op_t         o_op;
    op_is_t      o_op_is;
    tag_t        o_tag;
    addr_t       o_addr;
    data_t       o_retire_data;
    sel_t        o_lq_select, o_free_mask;
    logic [SQ_DEPTH-1:0] o_sq_select;
    logic [31:0] o_prdata;

    string       cur_test;
    int          test_errs;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    logic [31:0] rng = 32'd89665;
    sel_t        free_model = '1;
    cnt_t        exp_lookups = '0;
    cnt_t        exp_replays = '0;

    lsu_top #(
        .LQ_DEPTH        (LQ_DEPTH),
        .SQ_DEPTH        (SQ_DEPTH),
        .DC_OFFSET_WIDTH (DC_OFFSET_WIDTH)
    ) dut_i (.*);

    always #2 clk = ~clk;

    task automatic mismatch_report(input string what, input logic [63:0] exp,
                                   input logic [63:0] act);
        if (exp !== act) begin
            $display("FAIL %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic bit_matches(input string what, input logic exp, input logic act);
        mismatch_report(what, 64'(exp), 64'(act));
    endtask
    task automatic addr_matches(input string what, input addr_t exp, input addr_t act);
        mismatch_report(what, 64'(exp), 64'(act));
    endtask
    task automatic data_matches(input string what, input data_t exp, input data_t act);
        mismatch_report(what, 64'(exp), 64'(act));
    endtask
    task automatic tag_matches(input string what, input tag_t exp, input tag_t act);
        mismatch_report(what, 64'(exp), 64'(act));
    endtask
    task automatic op_matches(input string what, input op_t exp, input op_t act);
        mismatch_report(what, 64'(exp), 64'(act));
    endtask
    task automatic op_is_matches(input string what, input op_is_t exp, input op_is_t act);
        mismatch_report(what, 64'(exp), 64'(act));
    endtask
    task automatic count_matches(input string what, input cnt_t exp, input cnt_t act);
        mismatch_report(what, 64'(exp), 64'(act));
    endtask
    task automatic select_matches(input string what, input sel_t exp, input sel_t act);
        mismatch_report(what, 64'(exp), 64'(act));
    endtask
    task automatic sq_select_matches(input string what, input sq_sel_t exp,
                                     input sq_sel_t act);
        mismatch_report(what, 64'(exp), 64'(act));
    endtask

    function automatic logic [31:0] xorshift();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // Scan from entry 0 upward
    function automatic sel_t lowest_free(input sel_t mask);
        for (int b = 0; b < LQ_DEPTH; b++) begin
            if (mask[b]) begin
                return sel_t'(1) << b;
            end
        end
        return '0;
    endfunction

    task automatic open_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic close_test();
        if (test_errs == 0) begin
            $display("PASS %s", cur_test);
            pass_cnt++;
        end else begin
            $display("Test %s failed with %0d mismatches", cur_test, test_errs);
            fail_cnt++;
        end
    endtask

    task automatic apply_row(input int idx);
        row_t    r;
        addr_t   off;
        sel_t    exp_sel;
        op_is_t  exp_is;
        sq_sel_t exp_sq;
        r   = rows[idx];
        off = r.rnd ? (xorshift() & 32'hFFF) : r.offset;
        open_test(r.name);
        // Release lands at the agen edge, before the DW stage claims
        free_model = free_model | r.rel;
        exp_sel    = r.replay ? r.own_sel : lowest_free(free_model);
        // Load class in bit 0, store class in bit 1
        exp_is     = (r.op == OP_LOAD) ? 2'b01 : 2'b10;
        exp_sq     = sq_sel_t'(1) << (r.tag % SQ_DEPTH);
        @(posedge clk);
        i_valid     <= 1'b1;
        i_op        <= r.op;
        i_op_is     <= exp_is;
        i_tag       <= r.tag;
        i_base      <= r.base;
        i_offset    <= off;
        i_data      <= r.data;
        i_retire    <= r.tag[0];
        i_replay    <= r.replay;
        i_lq_select <= r.own_sel;
        i_sq_select <= exp_sq;
        i_lq_free   <= r.rel;
        i_fill_en   <= r.fill_en & ~r.fill_dw;
        i_fill_addr <= r.fill_line;
        i_flush     <= (r.flush == 2'd1);
        @(posedge clk);
        i_valid   <= 1'b0;
        i_lq_free <= '0;
        i_fill_en <= r.fill_en & r.fill_dw;
        i_flush   <= (r.flush == 2'd2);
        @(posedge clk);
        i_fill_en <= 1'b0;
        i_flush   <= 1'b0;
        @(negedge clk);
        if (r.flush != 2'd0) begin
            bit_matches("valid", 1'b0, o_valid);
            bit_matches("lookup", 1'b0, o_mhq_lookup_valid);
        end else begin
            bit_matches("valid", 1'b1, o_valid);
            bit_matches("lookup", r.exp_lookup, o_mhq_lookup_valid);
            bit_matches("fill_replay", r.exp_fill, o_fill_replay);
            addr_matches("addr", r.base + off, o_addr);
            tag_matches("tag", r.tag, o_tag);
            op_matches("op", r.op, o_op);
            op_is_matches("op_is", exp_is, o_op_is);
            data_matches("data", r.data, o_retire_data);
            bit_matches("retire", r.tag[0], o_retire);
            select_matches("lq_select", exp_sel, o_lq_select);
            sq_select_matches("sq_select", exp_sq, o_sq_select);
            if (r.op == OP_LOAD && !r.replay && !r.exp_fill) begin
                free_model = free_model & ~exp_sel;
            end
            exp_lookups += cnt_t'(r.exp_lookup);
            exp_replays += cnt_t'(r.exp_fill);
        end
        select_matches("free_mask", free_model, o_free_mask);
        close_test();
    endtask

    // Setup phase, then access phase sampled mid-cycle
    task automatic apb_transfer(input logic write, input apb_addr_t addr,
                                input logic [31:0] wdata, input logic exp_err,
                                output logic [31:0] rdata);
        @(posedge clk);
        i_psel    <= 1'b1;
        i_penable <= 1'b0;
        i_pwrite  <= write;
        i_paddr   <= addr;
        i_pwdata  <= wdata;
        @(posedge clk);
        i_penable <= 1'b1;
        @(negedge clk);
        rdata = o_prdata;
        bit_matches("pready", 1'b1, o_pready);
        bit_matches("pslverr", exp_err, o_pslverr);
        @(posedge clk);
        i_psel    <= 1'b0;
        i_penable <= 1'b0;
    endtask

    initial begin
        logic [31:0] rdata;
        repeat (8) @(posedge clk);
        i_arst_n <= 1'b1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_row(i);
        end
        // Let the last events reach the counters
        repeat (2) @(posedge clk);
        open_test("apb_counters");
        apb_transfer(1'b0, REG_LOOKUPS, '0, 1'b0, rdata);
        count_matches("lookups", exp_lookups, cnt_t'(rdata));
        apb_transfer(1'b0, REG_REPLAYS, '0, 1'b0, rdata);
        count_matches("replays", exp_replays, cnt_t'(rdata));
        apb_transfer(1'b0, REG_LQ_FREE, '0, 1'b0, rdata);
        select_matches("free_reg", free_model, sel_t'(rdata));
        close_test();
        open_test("apb_clear");
        apb_transfer(1'b1, REG_CTRL, 32'h1, 1'b0, rdata);
        apb_transfer(1'b0, REG_LOOKUPS, '0, 1'b0, rdata);
        count_matches("lookups", '0, cnt_t'(rdata));
        apb_transfer(1'b0, REG_REPLAYS, '0, 1'b0, rdata);
        count_matches("replays", '0, cnt_t'(rdata));
        close_test();
        open_test("apb_unmapped");
        apb_transfer(1'b0, 8'h40, '0, 1'b1, rdata);
        close_test();
        $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (NUM_ROWS * 10 + 200) @(posedge clk);
        $display("Timeout: the run did not complete in time, test %s was active", cur_test);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* rtl/lsu_top.sv */
/*
 * LSU front end top. An op issued with i_valid shows up two edges later.
 * No back-pressure: a new load must only be sent while an LQ entry is free.
 */

`timescale 1ns/1ps

module lsu_top #(
    parameter int LQ_DEPTH        = 8,
    parameter int SQ_DEPTH        = 8,
    parameter int DC_OFFSET_WIDTH = 5
) (
    input  logic                                          clk,
    input  logic                                          i_arst_n,
    input  logic                                          i_flush,
    input  logic                                          i_fill_en,
    input  logic [lsu_pkg::ADDR_WIDTH-1:DC_OFFSET_WIDTH]  i_fill_addr,
    input  logic                                          i_valid,
    input  lsu_pkg::op_t                                  i_op,
    input  lsu_pkg::op_is_t                               i_op_is,
    input  lsu_pkg::tag_t                                 i_tag,
    input  lsu_pkg::addr_t                                i_base,
    input  lsu_pkg::addr_t                                i_offset,
    input  lsu_pkg::data_t                                i_data,
    input  logic                                          i_retire,
    input  logic                                          i_replay,
    input  logic [LQ_DEPTH-1:0]                           i_lq_select,
    input  logic [SQ_DEPTH-1:0]                           i_sq_select,
    input  logic [LQ_DEPTH-1:0]                           i_lq_free,
    input  logic                                          i_psel,
    input  logic                                          i_penable,
    input  logic                                          i_pwrite,
    input  lsu_pkg::apb_addr_t                            i_paddr,
    input  logic [31:0]                                   i_pwdata,
    output logic                                          o_valid,
    output logic                                          o_mhq_lookup_valid,
    output logic                                          o_fill_replay,
    output lsu_pkg::op_t                                  o_op,
    output lsu_pkg::op_is_t                               o_op_is,
    output lsu_pkg::tag_t                                 o_tag,
    output lsu_pkg::addr_t                                o_addr,
    output lsu_pkg::data_t                                o_retire_data,
    output logic                                          o_retire,
    output logic [LQ_DEPTH-1:0]                           o_lq_select,
    output logic [SQ_DEPTH-1:0]                           o_sq_select,
    output logic [LQ_DEPTH-1:0]                           o_free_mask,
    output logic [31:0]                                   o_prdata,
    output logic                                          o_pready,
    output logic                                          o_pslverr
);

    import lsu_pkg::*;

    // Agen to DW
    logic                ag_valid;
    logic                ag_fill_replay;
    logic                ag_replay;
    op_t                 ag_op;
    op_is_t              ag_op_is;
    tag_t                ag_tag;
    addr_t               ag_addr;
    data_t               ag_data;
    logic                ag_retire;
    logic [LQ_DEPTH-1:0] ag_lq_select;
    logic [SQ_DEPTH-1:0] ag_sq_select;

    // DW and allocator handshake
    logic                claim_en;
    logic [LQ_DEPTH-1:0] claim_select;
    logic [LQ_DEPTH-1:0] alloc_select;

    lsu_agen_stage #(
        .LQ_DEPTH        (LQ_DEPTH),
        .SQ_DEPTH        (SQ_DEPTH),
        .DC_OFFSET_WIDTH (DC_OFFSET_WIDTH)
    ) agen_i (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_flush       (i_flush),
        .i_valid       (i_valid),
        .i_op          (i_op),
        .i_op_is       (i_op_is),
        .i_tag         (i_tag),
        .i_base        (i_base),
        .i_offset      (i_offset),
        .i_data        (i_data),
        .i_retire      (i_retire),
        .i_replay      (i_replay),
        .i_lq_select   (i_lq_select),
        .i_sq_select   (i_sq_select),
        .i_fill_en     (i_fill_en),
        .i_fill_addr   (i_fill_addr),
        .o_valid       (ag_valid),
        .o_fill_replay (ag_fill_replay),
        .o_replay      (ag_replay),
        .o_op          (ag_op),
        .o_op_is       (ag_op_is),
        .o_tag         (ag_tag),
        .o_addr        (ag_addr),
        .o_data        (ag_data),
        .o_retire      (ag_retire),
        .o_lq_select   (ag_lq_select),
        .o_sq_select   (ag_sq_select)
    );

    lsu_lq_alloc #(
        .LQ_DEPTH (LQ_DEPTH)
    ) lq_alloc_i (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_claim_en     (claim_en),
        .i_claim_select (claim_select),
        .i_lq_free      (i_lq_free),
        .o_alloc_select (alloc_select),
        .o_free_mask    (o_free_mask)
    );

    lsu_dw_stage #(
        .LQ_DEPTH        (LQ_DEPTH),
        .SQ_DEPTH        (SQ_DEPTH),
        .DC_OFFSET_WIDTH (DC_OFFSET_WIDTH)
    ) dw_i (
        .clk                (clk),
        .i_arst_n           (i_arst_n),
        .i_flush            (i_flush),
        .i_fill_en          (i_fill_en),
        .i_fill_addr        (i_fill_addr),
        .i_valid            (ag_valid),
        .i_fill_replay      (ag_fill_replay),
        .i_replay           (ag_replay),
        .i_op               (ag_op),
        .i_op_is            (ag_op_is),
        .i_tag              (ag_tag),
        .i_addr             (ag_addr),
        .i_data             (ag_data),
        .i_retire           (ag_retire),
        .i_lq_select        (ag_lq_select),
        .i_sq_select        (ag_sq_select),
        .i_alloc_lq_select  (alloc_select),
        .o_valid            (o_valid),
        .o_mhq_lookup_valid (o_mhq_lookup_valid),
        .o_fill_replay      (o_fill_replay),
        .o_op               (o_op),
        .o_op_is            (o_op_is),
        .o_tag              (o_tag),
        .o_addr             (o_addr),
        .o_retire_data      (o_retire_data),
        .o_retire           (o_retire),
        .o_lq_select        (o_lq_select),
        .o_sq_select        (o_sq_select),
        .o_claim_en         (claim_en),
        .o_claim_select     (claim_select)
    );

    // Fill replay is only counted for ops that survived the flush
    lsu_cfg_regs #(
        .LQ_DEPTH (LQ_DEPTH)
    ) cfg_regs_i (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_psel         (i_psel),
        .i_penable      (i_penable),
        .i_pwrite       (i_pwrite),
        .i_paddr        (i_paddr),
        .i_pwdata       (i_pwdata),
        .i_lookup_event (o_mhq_lookup_valid),
        .i_replay_event (o_valid & o_fill_replay),
        .i_free_mask    (o_free_mask),
        .o_prdata       (o_prdata),
        .o_pready       (o_pready),
        .o_pslverr      (o_pslverr)
    );

endmodule

/* rtl/lsu_cfg_regs.sv */
/*
 * APB register block with saturating 16-bit event counters. pready is tied
 * high. Only the low 32 bits of the free mask are visible. A clear wins over
 * an event in the same cycle.
 */

`timescale 1ns/1ps

module lsu_cfg_regs #(
    parameter int LQ_DEPTH = 8
) (
    input  logic               clk,
    input  logic               i_arst_n,
    input  logic               i_psel,
    input  logic               i_penable,
    input  logic               i_pwrite,
    input  lsu_pkg::apb_addr_t i_paddr,
    input  logic [31:0]        i_pwdata,
    input  logic               i_lookup_event,
    input  logic               i_replay_event,
    input  logic [LQ_DEPTH-1:0] i_free_mask,
    output logic [31:0]        o_prdata,
    output logic               o_pready,
    output logic               o_pslverr
);

    import lsu_pkg::*;

    logic access;
    logic addr_hit;
    logic clear;
    cnt_t lookups;
    cnt_t replays;

    function automatic cnt_t sat_inc(input cnt_t cnt, input logic ev);
        return (ev && (cnt != '1)) ? cnt + 1'b1 : cnt;
    endfunction

    assign access = i_psel & i_penable;
    assign clear  = access & i_pwrite & (i_paddr == REG_CTRL) & i_pwdata[0];

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            lookups <= '0;
            replays <= '0;
        end else if (clear) begin
            lookups <= '0;
            replays <= '0;
        end else begin
            lookups <= sat_inc(lookups, i_lookup_event);
            replays <= sat_inc(replays, i_replay_event);
        end
    end

    // Read mux, also used to flag unmapped addresses
    always_comb begin
        addr_hit = 1'b1;
        case (i_paddr)
            REG_CTRL:    o_prdata = '0;
            REG_LOOKUPS: o_prdata = 32'(lookups);
            REG_REPLAYS: o_prdata = 32'(replays);
            REG_LQ_FREE: o_prdata = 32'(i_free_mask);
            default: begin
                o_prdata = '0;
                addr_hit = 1'b0;
            end
        endcase
    end

    assign o_pready  = 1'b1;
    assign o_pslverr = access & ~addr_hit;

    // Access phase must follow a setup phase to the same slave
    a_apb_phase: assert property (@(posedge clk) disable iff (!i_arst_n)
        $rose(i_penable) |-> (i_psel && $past(i_psel)));

endmodule

/* rtl/lsu_dw_stage.sv */
/*
 * Hit-check and write-data stage. Claims a load-queue entry for new loads,
 * keeps the own entry of a replay, and blocks the miss lookup for any op
 * that collides with a fill. The claim is combinational from this stage's inputs.
 */

`timescale 1ns/1ps

module lsu_dw_stage #(
    parameter int LQ_DEPTH        = 8,
    parameter int SQ_DEPTH        = 8,
    parameter int DC_OFFSET_WIDTH = 5
) (
    input  logic                                          clk,
    input  logic                                          i_arst_n,
    input  logic                                          i_flush,
    input  logic                                          i_fill_en,
    input  logic [lsu_pkg::ADDR_WIDTH-1:DC_OFFSET_WIDTH]  i_fill_addr,
    input  logic                                          i_valid,
    input  logic                                          i_fill_replay,
    input  logic                                          i_replay,
    input  lsu_pkg::op_t                                  i_op,
    input  lsu_pkg::op_is_t                               i_op_is,
    input  lsu_pkg::tag_t                                 i_tag,
    input  lsu_pkg::addr_t                                i_addr,
    input  lsu_pkg::data_t                                i_data,
    input  logic                                          i_retire,
    input  logic [LQ_DEPTH-1:0]                           i_lq_select,
    input  logic [SQ_DEPTH-1:0]                           i_sq_select,
    input  logic [LQ_DEPTH-1:0]                           i_alloc_lq_select,
    output logic                                          o_valid,
    output logic                                          o_mhq_lookup_valid,
    output logic                                          o_fill_replay,
    output lsu_pkg::op_t                                  o_op,
    output lsu_pkg::op_is_t                               o_op_is,
    output lsu_pkg::tag_t                                 o_tag,
    output lsu_pkg::addr_t                                o_addr,
    output lsu_pkg::data_t                                o_retire_data,
    output logic                                          o_retire,
    output logic [LQ_DEPTH-1:0]                           o_lq_select,
    output logic [SQ_DEPTH-1:0]                           o_sq_select,
    output logic                                          o_claim_en,
    output logic [LQ_DEPTH-1:0]                           o_claim_select
);

    import lsu_pkg::*;

    logic                valid;
    logic                new_load;
    logic                fill_replay;
    logic [LQ_DEPTH-1:0] lq_select;

    assign valid    = i_valid & ~i_flush;
    assign new_load = valid & (i_op == OP_LOAD) & ~i_replay;

    // Conflict from agen, or a fill on the held line this cycle
    assign fill_replay = i_fill_replay |
                         (i_fill_en & (i_fill_addr == i_addr[ADDR_WIDTH-1:DC_OFFSET_WIDTH]));

    // Replayed ops already own an LQ entry
    assign lq_select = i_replay ? i_lq_select : i_alloc_lq_select;

    // A fill-replayed load comes back later, so it takes no entry now
    assign o_claim_en     = new_load & ~fill_replay;
    assign o_claim_select = i_alloc_lq_select;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_valid            <= 1'b0;
            o_mhq_lookup_valid <= 1'b0;
            o_fill_replay      <= 1'b0;
            o_retire           <= 1'b0;
        end else begin
            o_valid            <= valid;
            o_mhq_lookup_valid <= valid & ~fill_replay;
            o_fill_replay      <= fill_replay;
            o_retire           <= i_retire;
        end
    end

    always_ff @(posedge clk) begin
        o_op          <= i_op;
        o_op_is       <= i_op_is;
        o_tag         <= i_tag;
        o_addr        <= i_addr;
        o_retire_data <= i_data;
        o_lq_select   <= lq_select;
        o_sq_select   <= i_sq_select;
    end

    // Issue must hold back loads while the LQ is full
    a_alloc_avail: assert property (@(posedge clk) disable iff (!i_arst_n)
        new_load |-> (i_alloc_lq_select != '0));

endmodule

/* rtl/lsu_lq_alloc.sv */
/*
 * Load-queue allocator. Offers the lowest free entry, or zero when full.
 * There is no stall: the caller must not issue a new load into a full queue.
 */

`timescale 1ns/1ps

module lsu_lq_alloc #(
    parameter int LQ_DEPTH = 8
) (
    input  logic                clk,
    input  logic                i_arst_n,
    input  logic                i_claim_en,
    input  logic [LQ_DEPTH-1:0] i_claim_select,
    input  logic [LQ_DEPTH-1:0] i_lq_free,
    output logic [LQ_DEPTH-1:0] o_alloc_select,
    output logic [LQ_DEPTH-1:0] o_free_mask
);

    logic [LQ_DEPTH-1:0] claim_mask;

    assign claim_mask = i_claim_en ? i_claim_select : '0;

    // Isolate the lowest set bit of the free mask
    assign o_alloc_select = o_free_mask & (~o_free_mask + 1'b1);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_free_mask <= '1;
        end else begin
            o_free_mask <= (o_free_mask & ~claim_mask) | i_lq_free;
        end
    end

    // The DW stage may only claim the single entry that was offered as free
    a_claim_free: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_claim_en |-> ($onehot(i_claim_select) && ((i_claim_select & o_free_mask) != '0)));

    // Releases come from outside and must return entries still in use
    a_release_busy: assert property (@(posedge clk) disable iff (!i_arst_n)
        (i_lq_free & o_free_mask) == '0);

endmodule

/* rtl/lsu_agen_stage.sv */
/*
 * Address generation stage. The sum wraps at 32 bits and is not checked
 * for alignment. A fill on the new address's line marks the op for replay.
 */

`timescale 1ns/1ps

module lsu_agen_stage #(
    parameter int LQ_DEPTH        = 8,
    parameter int SQ_DEPTH        = 8,
    parameter int DC_OFFSET_WIDTH = 5
) (
    input  logic                                          clk,
    input  logic                                          i_arst_n,
    input  logic                                          i_flush,
    input  logic                                          i_valid,
    input  lsu_pkg::op_t                                  i_op,
    input  lsu_pkg::op_is_t                               i_op_is,
    input  lsu_pkg::tag_t                                 i_tag,
    input  lsu_pkg::addr_t                                i_base,
    input  lsu_pkg::addr_t                                i_offset,
    input  lsu_pkg::data_t                                i_data,
    input  logic                                          i_retire,
    input  logic                                          i_replay,
    input  logic [LQ_DEPTH-1:0]                           i_lq_select,
    input  logic [SQ_DEPTH-1:0]                           i_sq_select,
    input  logic                                          i_fill_en,
    input  logic [lsu_pkg::ADDR_WIDTH-1:DC_OFFSET_WIDTH]  i_fill_addr,
    output logic                                          o_valid,
    output logic                                          o_fill_replay,
    output logic                                          o_replay,
    output lsu_pkg::op_t                                  o_op,
    output lsu_pkg::op_is_t                               o_op_is,
    output lsu_pkg::tag_t                                 o_tag,
    output lsu_pkg::addr_t                                o_addr,
    output lsu_pkg::data_t                                o_data,
    output logic                                          o_retire,
    output logic [LQ_DEPTH-1:0]                           o_lq_select,
    output logic [SQ_DEPTH-1:0]                           o_sq_select
);

    import lsu_pkg::*;

    addr_t addr;
    logic  fill_hit;

    assign addr = i_base + i_offset;

    // Same line as a fill arriving this cycle, so the cache data is stale
    assign fill_hit = i_fill_en & (i_fill_addr == addr[ADDR_WIDTH-1:DC_OFFSET_WIDTH]);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_valid       <= 1'b0;
            o_fill_replay <= 1'b0;
            o_retire      <= 1'b0;
        end else begin
            o_valid       <= i_valid & ~i_flush;
            o_fill_replay <= fill_hit;
            o_retire      <= i_retire;
        end
    end

    // Payload follows valid
    always_ff @(posedge clk) begin
        o_replay    <= i_replay;
        o_op        <= i_op;
        o_op_is     <= i_op_is;
        o_tag       <= i_tag;
        o_addr      <= addr;
        o_data      <= i_data;
        o_lq_select <= i_lq_select;
        o_sq_select <= i_sq_select;
    end

endmodule

/* rtl/lsu_pkg.sv */
/*
 * Shared types, op codes and APB register offsets for the LSU front end.
 * Addresses and data are fixed at 32 bits, and the ROB index is 5 bits.
 */

package lsu_pkg;

    localparam int ADDR_WIDTH = 32;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [31:0]           data_t;
    typedef logic [4:0]            tag_t;
    typedef logic [1:0]            op_t;
    // One bit for load, one bit for store
    typedef logic [1:0]            op_is_t;
    typedef logic [15:0]           cnt_t;
    typedef logic [7:0]            apb_addr_t;

    localparam op_t OP_LOAD  = 2'd0;
    localparam op_t OP_STORE = 2'd1;

    // APB register map, byte offsets
    localparam apb_addr_t REG_CTRL    = 8'h00;
    localparam apb_addr_t REG_LOOKUPS = 8'h04;
    localparam apb_addr_t REG_REPLAYS = 8'h08;
    localparam apb_addr_t REG_LQ_FREE = 8'h0C;

endpackage
